// ==== sdhci.f ====
sdhci_pkg.sv
sd_clk_divider.sv
sd_cmd_crc7.sv
sd_cmd_phy.sv
sdhci_regs.sv
sdhci_top.sv
sd_card_model.sv
sdhci_assertions.sv
tb_sdhci.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SD host controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdhci -f sdhci.f
./obj_dir/Vtb_sdhci | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  exit 0
else
  exit 1
fi

// ==== tb_sdhci.sv ====
/* Testbench for the SD host controller
   Runs a command table against the card model and checks status, response and resets */

`timescale 1ns/10ps

module tb_sdhci;
  import sdhci_pkg::*;

  typedef struct packed {
    logic [5:0]  index;
    logic        resp;
    logic [1:0]  mode;
    logic [31:0] exp_status;
  } entry_t;

  localparam int unsigned NUM_ENTRIES = 6;
  localparam int unsigned CYCLE_LIMIT = NUM_ENTRIES * 400 + 2000;
  localparam logic [31:0] INT_EN_VALUE = 32'h1 << INT_ERROR;
  localparam logic [31:0] CLK_PERIOD_NS = 32'd100;
  localparam logic [31:0] SD_DIVIDER = 32'd1;
  localparam logic [31:0] SD_CLK_PERIOD_NS = 2 * (SD_DIVIDER + 1) * CLK_PERIOD_NS;

  logic        clk;
  logic        rst;
  obi_req_t    obi_req;
  obi_rsp_t    obi_rsp;
  logic        sd_clk;
  logic        sd_cmd_out;
  logic        sd_cmd_en;
  logic        sd_cmd_line;
  logic        irq;
  logic [1:0]  card_mode;
  logic [5:0]  seen_index;
  logic [31:0] seen_arg;
  logic        seen_ok;
  entry_t      tbl [NUM_ENTRIES];
  int unsigned cycles;
  int unsigned checks;
  int unsigned errors;

  sdhci_top i_dut (
    .clk_i                (clk),
    .software_reset_cmd_q (rst),
    .obi_req_i            (obi_req),
    .obi_rsp_o            (obi_rsp),
    .sd_clk_o             (sd_clk),
    .sd_cmd_o             (sd_cmd_out),
    .sd_cmd_en_o          (sd_cmd_en),
    .sd_cmd_i             (sd_cmd_line),
    .interrupt_o          (irq)
  );

  sd_card_model i_card (
    .sd_clk_i        (sd_clk),
    .host_cmd_i      (sd_cmd_out),
    .host_cmd_en_i   (sd_cmd_en),
    .mode_i          (card_mode),
    .line_o          (sd_cmd_line),
    .seen_index_o    (seen_index),
    .seen_arg_o      (seen_arg),
    .seen_frame_ok_o (seen_ok)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Drive one OBI request and hold it until gnt
  task automatic bus_request(input obi_req_t request);
    int unsigned waits;
    waits = 0;
    @(posedge clk);
    #1;
    obi_req = request;
    @(posedge clk);
    while (!obi_rsp.gnt) begin
      waits++;
      @(posedge clk);
    end
    #1;
    obi_req = '0;
    if (waits != 0) begin
      errors++;
      $display("OBI gnt for offset %h came %0d cycles late at %0t ns",
               request.addr[7:0], waits, $time);
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    obi_req_t request;
    request = '{req: 1'b1, we: 1'b1, be: 4'hF, addr: {24'h0, addr}, wdata: data};
    bus_request(request);
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    obi_req_t request;
    request = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: {24'h0, addr}, wdata: 32'h0};
    bus_request(request);
    if (!obi_rsp.rvalid) begin
      errors++;
      $display("Bus read of offset %h got no rvalid at %0t ns", addr, $time);
    end
    data = obi_rsp.rdata;
    err  = obi_rsp.err;
  endtask

  task automatic wait_cmd_complete;
    logic [31:0] st;
    logic        e;
    st = '0;
    while (!st[INT_CMD_COMPLETE]) bus_read(REG_INT_STATUS, st, e);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] arg;
    logic [31:0] cmd_word;
    logic        err;
    time         t_rise;
    clk       = 1'b0;
    rst       = 1'b1;
    obi_req   = '0;
    card_mode = 2'd0;
    cycles    = 0;
    checks    = 0;
    errors    = 0;
    arg       = $urandom(32'h8bd1_adf1);
    tbl[0] = '{6'd17, 1'b1, 2'd0, 32'h0000_0001};
    tbl[1] = '{6'd0,  1'b0, 2'd1, 32'h0000_0001};
    tbl[2] = '{6'd13, 1'b1, 2'd2, 32'h0002_8001};  // CRC error
    tbl[3] = '{6'd55, 1'b1, 2'd3, 32'h0008_8001};  // Index error
    tbl[4] = '{6'd8,  1'b1, 2'd1, 32'h0001_8001};  // Timeout
    tbl[5] = '{6'd2,  1'b1, 2'd0, 32'h0000_0001};
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Divider 1, enabled
    bus_write(REG_CLOCK_CONTROL, (SD_DIVIDER << CC_DIVIDER_LSB) | (32'h1 << CC_ENABLE_BIT));
    bus_write(REG_INT_ENABLE, INT_EN_VALUE);
    bus_read(REG_CLOCK_CONTROL, rd, err);
    check_value("clock stable", {31'h0, rd[CC_STABLE_BIT]}, 32'h1);
    @(posedge sd_clk);
    t_rise = $time;
    @(posedge sd_clk);
    check_value("sd clock period", 32'($time - t_rise), SD_CLK_PERIOD_NS);

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      card_mode = tbl[n].mode;
      arg       = $urandom;
      cmd_word  = '0;
      cmd_word[5:0]            = tbl[n].index;
      cmd_word[CMD_RESP_EXP_BIT] = tbl[n].resp;
      bus_write(REG_ARGUMENT, arg);
      bus_write(REG_COMMAND, cmd_word);
      wait_cmd_complete();
      bus_read(REG_INT_STATUS, rd, err);
      check_value("int status", rd, tbl[n].exp_status);
      check_value("interrupt", {31'h0, irq}, {31'h0, |(tbl[n].exp_status & INT_EN_VALUE)});
      if (tbl[n].resp && tbl[n].mode == 2'd0) begin
        bus_read(REG_RESPONSE0, rd, err);
        check_value("response0", rd, ~arg);
      end
      check_value("card index", {26'h0, seen_index}, {26'h0, tbl[n].index});
      check_value("card argument", seen_arg, arg);
      check_value("card frame ok", {31'h0, seen_ok}, 32'h1);
      bus_write(REG_INT_STATUS, 32'hFFFF_FFFF);
      bus_read(REG_INT_STATUS, rd, err);
      check_value("status after clear", rd, 32'h0);
      check_value("interrupt after clear", {31'h0, irq}, 32'h0);
      bus_read(REG_PRESENT_STATE, rd, err);
      check_value("cmd inhibit", {31'h0, rd[PS_CMD_INHIBIT_BIT]}, 32'h0);
    end

    bus_read(8'h20, rd, err);
    check_value("unmapped err", {31'h0, err}, 32'h1);

    bus_write(REG_INT_ENABLE, 32'h000F_8001);
    bus_write(REG_SOFTWARE_RESET, 32'h1 << SR_ALL_BIT);
    repeat (4) @(posedge clk);
    bus_read(REG_INT_ENABLE, rd, err);
    check_value("int enable after reset", rd, 32'h0);
    bus_read(REG_CLOCK_CONTROL, rd, err);
    check_value("clock control after reset", rd, 32'h0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sdhci_assertions.sv ====
/* Protocol checks on the OBI port and the CMD line driver */

`timescale 1ns/10ps

module sdhci_assertions (
  input logic clk_i,
  input logic rst_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic cmd_start_i,
  input logic cmd_done_i,
  input logic sd_cmd_en_i
);
  logic busy_q;  // Between launch and completion

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (cmd_start_i) begin
      busy_q <= 1'b1;
    end else if (cmd_done_i) begin
      busy_q <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) gnt_i |=> rvalid_i)
    else $error("OBI rvalid missing one cycle after gnt");

  assert property (@(posedge clk_i) disable iff (rst_i) sd_cmd_en_i |-> busy_q)
    else $error("CMD line driven with no command in flight");

  // Phy is idle at launch and at completion
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (cmd_start_i || cmd_done_i) |-> !sd_cmd_en_i)
    else $error("CMD line driven while phy idle");

endmodule

bind sdhci_top sdhci_assertions i_assertions (
  .clk_i       (clk_i),
  .rst_i       (regs_rst),
  .gnt_i       (obi_rsp_o.gnt),
  .rvalid_i    (obi_rsp_o.rvalid),
  .cmd_start_i (cmd_req.start),
  .cmd_done_i  (cmd_rsp.done),
  .sd_cmd_en_i (sd_cmd_en_o)
);

// ==== sd_card_model.sv ====
/* SD card model for the CMD line
   Captures host commands and answers with R1 in one of four modes */

`timescale 1ns/10ps

module sd_card_model (
  input  logic        sd_clk_i,
  input  logic        host_cmd_i,
  input  logic        host_cmd_en_i,
  input  logic [1:0]  mode_i,        // 0 normal, 1 silent, 2 bad CRC, 3 wrong index
  output logic        line_o,
  output logic [5:0]  seen_index_o,
  output logic [31:0] seen_arg_o,
  output logic        seen_frame_ok_o
);
  logic        drv_en;
  logic        drv_bit;
  logic [47:0] rx_frame;
  logic [47:0] tx_frame;
  logic [6:0]  tx_crc;

  // Pull-up when nobody drives
  assign line_o = host_cmd_en_i ? host_cmd_i : (drv_en ? drv_bit : 1'b1);

  // CRC7 of a 40-bit payload, x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7_of(input logic [39:0] data);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  initial begin
    drv_en          = 1'b0;
    drv_bit         = 1'b1;
    seen_index_o    = '0;
    seen_arg_o      = '0;
    seen_frame_ok_o = 1'b0;
    forever begin
      @(posedge sd_clk_i);
      if (host_cmd_en_i && !host_cmd_i) begin
        rx_frame = {47'h0, host_cmd_i};
        repeat (47) begin
          @(posedge sd_clk_i);
          rx_frame = {rx_frame[46:0], host_cmd_i};
        end
        seen_index_o    = rx_frame[45:40];
        seen_arg_o      = rx_frame[39:8];
        seen_frame_ok_o = rx_frame[46] && rx_frame[0]
                          && (rx_frame[7:1] == crc7_of(rx_frame[47:8]));
        if (mode_i != 2'd1) begin
          tx_frame[47:40] = {2'b00, rx_frame[45:40] ^ ((mode_i == 2'd3) ? 6'h01 : 6'h00)};
          tx_frame[39:8]  = ~rx_frame[39:8];  // Card status is the inverted argument
          tx_crc          = crc7_of(tx_frame[47:8]);
          if (mode_i == 2'd2) tx_crc = tx_crc ^ 7'h01;
          tx_frame[7:0]   = {tx_crc, 1'b1};
          repeat (2) @(negedge sd_clk_i);  // Host releases the line first
          for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk_i);
            drv_en  = 1'b1;
            drv_bit = tx_frame[i];
          end
          @(negedge sd_clk_i);
          drv_en = 1'b0;
        end
      end
    end
  end

endmodule

// ==== sdhci_top.sv ====
/* SD host controller, command line only
   Soft-reset sequencing around the register file, clock divider and CMD engine */

`timescale 1ns/10ps

module sdhci_top (
  input  logic                clk_i,
  input  logic                software_reset_cmd_q,
  input  sdhci_pkg::obi_req_t obi_req_i,
  output sdhci_pkg::obi_rsp_t obi_rsp_o,
  output logic                sd_clk_o,
  output logic                sd_cmd_o,
  output logic                sd_cmd_en_o,
  input  logic                sd_cmd_i,
  output logic                interrupt_o
);
  import sdhci_pkg::*;

  logic     software_reset_all_q;
  logic     cmd_soft_reset_q;
  logic     reset_all_req;
  logic     reset_cmd_req;
  logic     regs_rst;
  logic     phy_rst;
  cmd_req_t cmd_req;
  cmd_rsp_t cmd_rsp;
  clk_cfg_t clk_cfg;
  logic     sd_rise;
  logic     sd_fall;
  logic     sd_clk_stable;

  // Register bits land here one cycle after they are set
  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      software_reset_all_q <= 1'b0;
      cmd_soft_reset_q     <= 1'b0;
    end else begin
      software_reset_all_q <= reset_all_req;
      cmd_soft_reset_q     <= reset_cmd_req;  // cmd line only
    end
  end

  assign regs_rst = software_reset_cmd_q || software_reset_all_q;
  assign phy_rst  = regs_rst || cmd_soft_reset_q;

  sdhci_regs i_regs (
    .clk_i,
    .software_reset_cmd_q (regs_rst),
    .obi_req_i,
    .obi_rsp_o,
    .cmd_req_o            (cmd_req),
    .cmd_rsp_i            (cmd_rsp),
    .clk_cfg_o            (clk_cfg),
    .sd_clk_stable_i      (sd_clk_stable),
    .sd_cmd_level_i       (sd_cmd_i),
    .reset_all_o          (reset_all_req),
    .reset_cmd_o          (reset_cmd_req),
    .interrupt_o
  );

  sd_clk_divider i_sd_clk_divider (
    .clk_i,
    .rst_i           (regs_rst),
    .clk_cfg_i       (clk_cfg),
    .sd_clk_o,
    .sd_rise_o       (sd_rise),
    .sd_fall_o       (sd_fall),
    .sd_clk_stable_o (sd_clk_stable)
  );

  sd_cmd_phy i_sd_cmd_phy (
    .clk_i,
    .rst_i       (phy_rst),
    .sd_rise_i   (sd_rise),
    .sd_fall_i   (sd_fall),
    .cmd_req_i   (cmd_req),
    .cmd_rsp_o   (cmd_rsp),
    .sd_cmd_o,
    .sd_cmd_en_o,
    .sd_cmd_i
  );

endmodule

// ==== sdhci_regs.sv ====
/* SD host register file on OBI
   W1C interrupt status with enable mask, command launch, self-clearing resets */

`timescale 1ns/10ps

module sdhci_regs (
  input  logic                clk_i,
  input  logic                software_reset_cmd_q,
  input  sdhci_pkg::obi_req_t obi_req_i,
  output sdhci_pkg::obi_rsp_t obi_rsp_o,
  output sdhci_pkg::cmd_req_t cmd_req_o,
  input  sdhci_pkg::cmd_rsp_t cmd_rsp_i,
  output sdhci_pkg::clk_cfg_t clk_cfg_o,
  input  logic                sd_clk_stable_i,
  input  logic                sd_cmd_level_i,
  output logic                reset_all_o,
  output logic                reset_cmd_o,
  output logic                interrupt_o
);
  import sdhci_pkg::*;

  logic [7:0]  offset;
  logic        wr_en;
  logic [31:0] be_mask;
  logic        cmd_accept;
  logic [31:0] rdata_d;
  logic        err_d;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  logic [31:0] argument_q;
  logic [5:0]  cmd_index_q;
  logic        cmd_resp_q;
  logic        cmd_start_q;
  logic        cmd_inhibit_q;
  logic [31:0] response0_q;
  logic [31:0] status_q;
  logic [31:0] status_set;
  logic [31:0] status_clr;
  logic [31:0] int_status;
  logic [31:0] int_enable_q;
  logic        clk_enable_q;
  logic [7:0]  clk_divider_q;
  logic        reset_all_q;
  logic        reset_cmd_q;
  logic        irq_q;

  assign offset  = obi_req_i.addr[7:0];
  assign wr_en   = obi_req_i.req && obi_req_i.we;
  assign be_mask = {{8{obi_req_i.be[3]}}, {8{obi_req_i.be[2]}},
                    {8{obi_req_i.be[1]}}, {8{obi_req_i.be[0]}}};
  // Writes while a command is in flight are dropped
  assign cmd_accept = wr_en && (offset == REG_COMMAND) && !cmd_inhibit_q;

  always_comb begin
    status_set                   = '0;
    status_set[INT_CMD_COMPLETE] = cmd_rsp_i.done;
    status_set[INT_CMD_TIMEOUT]  = cmd_rsp_i.done && cmd_rsp_i.timeout_err;
    status_set[INT_CMD_CRC]      = cmd_rsp_i.done && cmd_rsp_i.crc_err;
    status_set[INT_CMD_END_BIT]  = cmd_rsp_i.done && cmd_rsp_i.end_bit_err;
    status_set[INT_CMD_INDEX]    = cmd_rsp_i.done && cmd_rsp_i.index_err;
  end

  assign status_clr = (wr_en && offset == REG_INT_STATUS) ? (obi_req_i.wdata & be_mask) : '0;

  always_comb begin
    int_status            = status_q;
    int_status[INT_ERROR] = |status_q[INT_CMD_INDEX:INT_CMD_TIMEOUT];
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cmd_index_q   <= '0;
      cmd_resp_q    <= 1'b0;
      cmd_start_q   <= 1'b0;
      cmd_inhibit_q <= 1'b0;
      status_q      <= '0;
      int_enable_q  <= '0;
      clk_enable_q  <= 1'b0;
      clk_divider_q <= '0;
      reset_all_q   <= 1'b0;
      reset_cmd_q   <= 1'b0;
      irq_q         <= 1'b0;
      rvalid_q      <= 1'b0;
    end else begin
      rvalid_q    <= obi_req_i.req;  // gnt is req, answer next cycle
      cmd_start_q <= cmd_accept;
      if (cmd_accept) begin
        if (obi_req_i.be[0]) cmd_index_q <= obi_req_i.wdata[CMD_INDEX_LSB +: 6];
        if (obi_req_i.be[1]) cmd_resp_q <= obi_req_i.wdata[CMD_RESP_EXP_BIT];
      end
      // A timeout leaves inhibit to the cmd-line reset
      if (reset_cmd_q) begin
        cmd_inhibit_q <= 1'b0;
      end else if (cmd_accept) begin
        cmd_inhibit_q <= 1'b1;
      end else if (cmd_rsp_i.done && !cmd_rsp_i.timeout_err) begin
        cmd_inhibit_q <= 1'b0;
      end
      status_q <= (status_q & ~status_clr) | status_set;  // set wins over clear
      if (wr_en && offset == REG_INT_ENABLE) begin
        int_enable_q <= (int_enable_q & ~be_mask) | (obi_req_i.wdata & be_mask);
      end
      if (wr_en && offset == REG_CLOCK_CONTROL) begin
        if (obi_req_i.be[0]) clk_enable_q <= obi_req_i.wdata[CC_ENABLE_BIT];
        if (obi_req_i.be[1]) clk_divider_q <= obi_req_i.wdata[CC_DIVIDER_LSB +: 8];
      end
      reset_all_q <= wr_en && offset == REG_SOFTWARE_RESET && obi_req_i.be[0]
                     && obi_req_i.wdata[SR_ALL_BIT];
      reset_cmd_q <= (wr_en && offset == REG_SOFTWARE_RESET && obi_req_i.be[0]
                      && obi_req_i.wdata[SR_CMD_BIT]) || status_set[INT_CMD_TIMEOUT];
      irq_q <= |(int_status & int_enable_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && offset == REG_ARGUMENT) begin
      argument_q <= (argument_q & ~be_mask) | (obi_req_i.wdata & be_mask);
    end
    if (cmd_rsp_i.done && cmd_rsp_i.resp_valid) response0_q <= cmd_rsp_i.response;
    if (obi_req_i.req) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (offset)
      REG_ARGUMENT:  rdata_d = argument_q;
      REG_COMMAND: begin
        rdata_d[CMD_INDEX_LSB +: 6]  = cmd_index_q;
        rdata_d[CMD_RESP_EXP_BIT]    = cmd_resp_q;
      end
      REG_RESPONSE0: rdata_d = response0_q;
      REG_PRESENT_STATE: begin
        rdata_d[PS_CMD_INHIBIT_BIT] = cmd_inhibit_q;
        rdata_d[PS_CMD_LEVEL_BIT]   = sd_cmd_level_i;
      end
      REG_INT_STATUS: rdata_d = int_status;
      REG_INT_ENABLE: rdata_d = int_enable_q;
      REG_CLOCK_CONTROL: begin
        rdata_d[CC_ENABLE_BIT]       = clk_enable_q;
        rdata_d[CC_STABLE_BIT]       = sd_clk_stable_i;
        rdata_d[CC_DIVIDER_LSB +: 8] = clk_divider_q;
      end
      REG_SOFTWARE_RESET: begin
        rdata_d[SR_ALL_BIT] = reset_all_q;
        rdata_d[SR_CMD_BIT] = reset_cmd_q;
      end
      default: err_d = 1'b1;  // Unmapped offset
    endcase
  end

  assign obi_rsp_o.gnt    = obi_req_i.req;
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.rdata  = rdata_q;
  assign obi_rsp_o.err    = err_q;

  assign cmd_req_o.start         = cmd_start_q;
  assign cmd_req_o.index         = cmd_index_q;
  assign cmd_req_o.argument      = argument_q;
  assign cmd_req_o.resp_expected = cmd_resp_q;

  assign clk_cfg_o.sd_clk_enable = clk_enable_q;
  assign clk_cfg_o.divider       = clk_divider_q;

  assign reset_all_o = reset_all_q;
  assign reset_cmd_o = reset_cmd_q;
  assign interrupt_o = irq_q;

endmodule

// ==== sd_cmd_phy.sv ====
/* SD CMD line engine
   Sends a 48-bit command, collects the R1 response and flags its errors */

`timescale 1ns/10ps

module sd_cmd_phy (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                sd_rise_i,
  input  logic                sd_fall_i,
  input  sdhci_pkg::cmd_req_t cmd_req_i,
  output sdhci_pkg::cmd_rsp_t cmd_rsp_o,
  output logic                sd_cmd_o,
  output logic                sd_cmd_en_o,
  input  logic                sd_cmd_i
);
  import sdhci_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT_RSP,
    ST_RECV,
    ST_FINISH
  } state_e;

  state_e                    state_q;
  logic [CMD_FRAME_BITS-1:0] sr_q;  // Shared by transmit and receive
  logic [5:0]                bit_cnt_q;
  logic [6:0]                wait_cnt_q;
  logic [5:0]                index_q;
  logic                      resp_exp_q;
  logic                      timeout_q;
  logic                      cmd_q;
  logic                      cmd_en_q;
  cmd_rsp_t                  rsp_q;
  logic [6:0]                tx_crc;
  logic [6:0]                rx_crc;
  logic [2:0]                crc_idx;
  logic                      tx_bit;
  logic                      crc_clear;
  logic                      tx_crc_shift;
  logic                      rx_crc_shift;
  logic                      rx_check;

  // Frame bits 0..39 carry payload, 40..46 CRC7, 47 the end bit
  always_comb begin
    crc_idx = 3'(6'(CMD_FRAME_BITS - 2) - bit_cnt_q);
    if (bit_cnt_q < 6'(CMD_FRAME_BITS - 8)) begin
      tx_bit = sr_q[CMD_FRAME_BITS-1];
    end else if (bit_cnt_q < 6'(CMD_FRAME_BITS - 1)) begin
      tx_bit = tx_crc[crc_idx];
    end else begin
      tx_bit = 1'b1;
    end
  end

  assign crc_clear    = (state_q == ST_IDLE);
  assign tx_crc_shift = sd_fall_i && (state_q == ST_SEND)
                        && (bit_cnt_q < 6'(CMD_FRAME_BITS - 8));
  // Start bit is found in the wait state and counts toward the CRC
  assign rx_crc_shift = sd_rise_i && (((state_q == ST_WAIT_RSP) && !sd_cmd_i)
                        || ((state_q == ST_RECV) && (bit_cnt_q < 6'(CMD_FRAME_BITS - 8))));
  assign rx_check     = resp_exp_q && !timeout_q;

  sd_cmd_crc7 i_tx_crc (
    .clk_i,
    .clear_i (crc_clear),
    .shift_i (tx_crc_shift),
    .bit_i   (tx_bit),
    .crc_o   (tx_crc)
  );

  sd_cmd_crc7 i_rx_crc (
    .clk_i,
    .clear_i (crc_clear),
    .shift_i (rx_crc_shift),
    .bit_i   (sd_cmd_i),
    .crc_o   (rx_crc)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      sr_q       <= '0;
      bit_cnt_q  <= '0;
      wait_cnt_q <= '0;
      index_q    <= '0;
      resp_exp_q <= 1'b0;
      timeout_q  <= 1'b0;
      cmd_q      <= 1'b1;
      cmd_en_q   <= 1'b0;
      rsp_q      <= '0;
    end else begin
      rsp_q.done <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (cmd_req_i.start) begin
            sr_q       <= {2'b01, cmd_req_i.index, cmd_req_i.argument, 8'h00};
            index_q    <= cmd_req_i.index;
            resp_exp_q <= cmd_req_i.resp_expected;
            timeout_q  <= 1'b0;
            bit_cnt_q  <= '0;
            state_q    <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (sd_fall_i) begin
            if (bit_cnt_q == 6'(CMD_FRAME_BITS)) begin
              cmd_en_q   <= 1'b0;  // Release, pull-up holds the line
              cmd_q      <= 1'b1;
              bit_cnt_q  <= '0;
              wait_cnt_q <= resp_exp_q ? 7'd0 : 7'd2;  // 2 SD clocks without response
              state_q    <= resp_exp_q ? ST_WAIT_RSP : ST_FINISH;
            end else begin
              cmd_en_q  <= 1'b1;
              cmd_q     <= tx_bit;
              sr_q      <= {sr_q[CMD_FRAME_BITS-2:0], 1'b0};
              bit_cnt_q <= bit_cnt_q + 6'd1;
            end
          end
        end
        ST_WAIT_RSP: begin
          if (sd_rise_i) begin
            if (!sd_cmd_i) begin
              sr_q      <= {sr_q[CMD_FRAME_BITS-2:0], sd_cmd_i};
              bit_cnt_q <= 6'd1;
              state_q   <= ST_RECV;
            end else if (wait_cnt_q == 7'(CMD_RESP_TIMEOUT - 1)) begin
              timeout_q  <= 1'b1;
              wait_cnt_q <= '0;
              state_q    <= ST_FINISH;
            end else begin
              wait_cnt_q <= wait_cnt_q + 7'd1;
            end
          end
        end
        ST_RECV: begin
          if (sd_rise_i) begin
            sr_q      <= {sr_q[CMD_FRAME_BITS-2:0], sd_cmd_i};
            bit_cnt_q <= bit_cnt_q + 6'd1;
            if (bit_cnt_q == 6'(CMD_FRAME_BITS - 1)) begin
              wait_cnt_q <= '0;
              state_q    <= ST_FINISH;
            end
          end
        end
        ST_FINISH: begin
          if (wait_cnt_q == '0) begin
            rsp_q.done        <= 1'b1;
            rsp_q.resp_valid  <= rx_check;
            rsp_q.response    <= sr_q[39:8];
            rsp_q.timeout_err <= timeout_q;
            rsp_q.crc_err     <= rx_check && (sr_q[7:1] != rx_crc);
            rsp_q.end_bit_err <= rx_check && !sr_q[0];
            // Direction bit must be 0 from the card
            rsp_q.index_err   <= rx_check && (sr_q[46] || (sr_q[45:40] != index_q));
            state_q           <= ST_IDLE;
          end else if (sd_rise_i) begin
            wait_cnt_q <= wait_cnt_q - 7'd1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign cmd_rsp_o   = rsp_q;
  assign sd_cmd_o    = cmd_q;
  assign sd_cmd_en_o = cmd_en_q;

endmodule

// ==== sd_cmd_crc7.sv ====
/* Serial CRC7 for SD command and response frames, x^7 + x^3 + 1 */

`timescale 1ns/10ps

module sd_cmd_crc7 (
  input  logic       clk_i,
  input  logic       clear_i,
  input  logic       shift_i,
  input  logic       bit_i,
  output logic [6:0] crc_o
);
  logic [6:0] crc_q;
  logic       feedback;

  assign feedback = bit_i ^ crc_q[6];

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      crc_q <= '0;
    end else if (shift_i) begin
      crc_q <= {crc_q[5:3], crc_q[2] ^ feedback, crc_q[1:0], feedback};
    end
  end

  assign crc_o = crc_q;

endmodule

// ==== sd_clk_divider.sv ====
/* SD clock divider
   Period of 2*(divider+1) system clocks, with edge strobes and a stable flag */

`timescale 1ns/10ps

module sd_clk_divider (
  input  logic                clk_i,
  input  logic                rst_i,
  input  sdhci_pkg::clk_cfg_t clk_cfg_i,
  output logic                sd_clk_o,
  output logic                sd_rise_o,
  output logic                sd_fall_o,
  output logic                sd_clk_stable_o
);
  logic [7:0] cnt_q;
  logic       sd_clk_q;
  logic       toggle;
  logic [1:0] stable_q;

  // >= so a smaller divider written mid-count takes effect at once
  assign toggle    = clk_cfg_i.sd_clk_enable && (cnt_q >= clk_cfg_i.divider);
  assign sd_rise_o = toggle && !sd_clk_q;  // sd_clk_o rises on this edge
  assign sd_fall_o = toggle && sd_clk_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
      stable_q <= '0;
    end else begin
      stable_q <= {stable_q[0] && clk_cfg_i.sd_clk_enable, clk_cfg_i.sd_clk_enable};
      if (!clk_cfg_i.sd_clk_enable) begin
        cnt_q    <= '0;  // Gated, park low
        sd_clk_q <= 1'b0;
      end else if (toggle) begin
        cnt_q    <= '0;
        sd_clk_q <= !sd_clk_q;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

  assign sd_clk_o        = sd_clk_q;
  assign sd_clk_stable_o = stable_q[1];

endmodule

// ==== sdhci_pkg.sv ====
/* SD host controller shared types and constants
   Register map, status bit positions, bus and command structs */

package sdhci_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } obi_rsp_t;

  // Register file to command phy
  typedef struct packed {
    logic        start;
    logic [5:0]  index;
    logic [31:0] argument;
    logic        resp_expected;
  } cmd_req_t;

  typedef struct packed {
    logic        done;
    logic        resp_valid;
    logic [31:0] response;     // Card status field of R1
    logic        timeout_err;
    logic        crc_err;
    logic        end_bit_err;
    logic        index_err;
  } cmd_rsp_t;

  typedef struct packed {
    logic       sd_clk_enable;
    logic [7:0] divider;
  } clk_cfg_t;

  localparam logic [7:0] REG_ARGUMENT       = 8'h00;
  localparam logic [7:0] REG_COMMAND        = 8'h04;
  localparam logic [7:0] REG_RESPONSE0      = 8'h08;
  localparam logic [7:0] REG_PRESENT_STATE  = 8'h0C;
  localparam logic [7:0] REG_INT_STATUS     = 8'h10;
  localparam logic [7:0] REG_INT_ENABLE     = 8'h14;
  localparam logic [7:0] REG_CLOCK_CONTROL  = 8'h18;
  localparam logic [7:0] REG_SOFTWARE_RESET = 8'h1C;

  // INT_STATUS word
  localparam int unsigned INT_CMD_COMPLETE = 0;
  localparam int unsigned INT_ERROR        = 15;  // Summary of bits 16..19
  localparam int unsigned INT_CMD_TIMEOUT  = 16;
  localparam int unsigned INT_CMD_CRC      = 17;
  localparam int unsigned INT_CMD_END_BIT  = 18;
  localparam int unsigned INT_CMD_INDEX    = 19;

  localparam int unsigned CMD_INDEX_LSB    = 0;
  localparam int unsigned CMD_RESP_EXP_BIT = 8;

  localparam int unsigned PS_CMD_INHIBIT_BIT = 0;
  localparam int unsigned PS_CMD_LEVEL_BIT   = 1;

  localparam int unsigned CC_ENABLE_BIT  = 0;
  localparam int unsigned CC_STABLE_BIT  = 1;  // Read only
  localparam int unsigned CC_DIVIDER_LSB = 8;

  localparam int unsigned SR_ALL_BIT = 0;
  localparam int unsigned SR_CMD_BIT = 1;

  // In SD clocks
  localparam int unsigned CMD_RESP_TIMEOUT = 64;
  localparam int unsigned CMD_FRAME_BITS   = 48;

endpackage
